// ==== rtl/pcmfmPkg.sv ====
package pcmfmPkg;

  localparam int rotBits    = 10;           // one real or imag component
  localparam int numPts     = 20;           // phasors, 18 deg apart
  localparam int idxBits    = 5;            // enough for 0..19
  localparam int metricBits = rotBits + 1;  // sum of two rotated reals
  localparam int apbAddrBits = 4;

  // register map
  localparam logic [apbAddrBits-1:0] ctrlAddr   = 4'h0;  // bit 0 enable
  localparam logic [apbAddrBits-1:0] resultAddr = 4'h4;  // idx and metric, read only
  localparam logic [apbAddrBits-1:0] countAddr  = 4'h8;  // result count, read only

  typedef struct packed {
    logic signed [rotBits-1:0] re;  // real part
    logic signed [rotBits-1:0] im;  // imag part
  } cplx_t;

  typedef struct packed {
    cplx_t samp0;  // first sample of symbol
    cplx_t samp1;  // second sample
  } symPair_t;

  typedef struct packed {
    cplx_t rot0;  // samp0 rotated
    cplx_t rot1;  // samp1 rotated
  } rotPair_t;

  typedef struct packed {
    logic        [idxBits-1:0]    bestIdx;     // winning phasor
    logic signed [metricBits-1:0] bestMetric;  // its summed real part
  } phaseResult_t;

  // unit circle, scaled by 511, entry 0 at 0 deg and stepping by -18 deg
  localparam cplx_t phasorTable [numPts] = '{
    '{re: 10'h1FF, im: 10'h000},  // 0 deg
    '{re: 10'h1E6, im: 10'h362},
    '{re: 10'h19D, im: 10'h2D4},
    '{re: 10'h12C, im: 10'h263},
    '{re: 10'h09E, im: 10'h21A},
    '{re: 10'h000, im: 10'h201},  // -90 deg
    '{re: 10'h362, im: 10'h21A},
    '{re: 10'h2D4, im: 10'h263},
    '{re: 10'h263, im: 10'h2D4},
    '{re: 10'h21A, im: 10'h362},
    '{re: 10'h201, im: 10'h000},  // 180 deg
    '{re: 10'h21A, im: 10'h09E},
    '{re: 10'h263, im: 10'h12C},
    '{re: 10'h2D4, im: 10'h19D},
    '{re: 10'h362, im: 10'h1E6},
    '{re: 10'h000, im: 10'h1FF},  // +90 deg
    '{re: 10'h09E, im: 10'h1E6},
    '{re: 10'h12C, im: 10'h19D},
    '{re: 10'h19D, im: 10'h12C},
    '{re: 10'h1E6, im: 10'h09E}
  };

endpackage

// ==== rtl/rotMult.sv ====
`timescale 1ns/1ps

module rotMult (
  input  logic              clk,
  input  pcmfmPkg::cplx_t   a,       // sample currently presented
  input  pcmfmPkg::cplx_t   phasor,  // fixed rotation point
  output pcmfmPkg::rotPair_t prod,   // rotated samp0 and samp1
  input  logic              sel1     // high while samp1 is presented
);

  // full precision products, 2*rotBits+1 bits holds the sum without overflow
  logic signed [2*pcmfmPkg::rotBits:0] reFull;
  logic signed [2*pcmfmPkg::rotBits:0] imFull;
  pcmfmPkg::cplx_t                     scaled;  // after the >>> (rotBits-1)

  always_comb begin
    reFull = a.re * phasor.re - a.im * phasor.im;  // ac - bd
    imFull = a.re * phasor.im + a.im * phasor.re;  // ad + bc
  end

  // slicing from bit rotBits-1 is the arithmetic shift, low rotBits kept
  always_comb begin
    scaled.re = reFull[2*pcmfmPkg::rotBits-2:pcmfmPkg::rotBits-1];
    scaled.im = imFull[2*pcmfmPkg::rotBits-2:pcmfmPkg::rotBits-1];
  end

  // one multiplier, two result slots
  always_ff @(posedge clk) begin
    if (sel1) begin
      prod.rot1 <= scaled;  // second cycle of symbol
    end else begin
      prod.rot0 <= scaled;  // first cycle, also idle cycles
    end
  end

endmodule

// ==== rtl/rotator.sv ====
`timescale 1ns/1ps

module rotator (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        symEn,
  input  logic                                        enable,   // from ctrl register
  input  pcmfmPkg::symPair_t                          sampIn,
  output pcmfmPkg::rotPair_t [pcmfmPkg::numPts-1:0]   rotOut,
  output logic                                        rotValid
);

  logic               symGate;   // symEn qualified by enable
  logic               stage1;    // samp0 on the multipliers
  logic               stage2;    // samp1 on the multipliers
  pcmfmPkg::symPair_t sampBuf;   // held symbol pair
  pcmfmPkg::cplx_t    sampSel;   // shared multiplier input

  assign symGate = symEn & enable;

  // payload capture, no reset needed
  always_ff @(posedge clk) begin
    if (symGate) begin
      sampBuf <= sampIn;
    end
  end

  // two-stage strobe, then rotValid
  always_ff @(posedge clk) begin
    if (rst) begin
      stage1   <= 1'b0;
      stage2   <= 1'b0;
      rotValid <= 1'b0;
    end else begin
      stage1   <= symGate;
      stage2   <= stage1;
      rotValid <= stage2;  // both slots written by now
    end
  end

  // samp0 by default, samp1 only in the second stage
  assign sampSel = stage2 ? sampBuf.samp1 : sampBuf.samp0;

  for (genvar k = 0; k < pcmfmPkg::numPts; k++) begin : gPt
    rotMult rotMult_i (
      .clk    (clk),
      .a      (sampSel),
      .phasor (pcmfmPkg::phasorTable[k]),  // point k+1 of the circle
      .prod   (rotOut[k]),
      .sel1   (stage2)
    );
  end

endmodule

// ==== rtl/phaseSearch.sv ====
`timescale 1ns/1ps

module phaseSearch (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      rotValid,
  input  pcmfmPkg::rotPair_t [pcmfmPkg::numPts-1:0] rotOut,
  output pcmfmPkg::phaseResult_t                    result,
  output logic                                      resultValid
);

  // per-phasor metric, real part of both rotated samples
  logic signed [pcmfmPkg::metricBits-1:0] metric [pcmfmPkg::numPts];

  logic        [pcmfmPkg::idxBits-1:0]    scanIdx;     // running winner
  logic signed [pcmfmPkg::metricBits-1:0] scanMetric;  // running maximum

  always_comb begin
    for (int k = 0; k < pcmfmPkg::numPts; k++) begin
      // sign-extend each real part one bit before adding
      metric[k] = {rotOut[k].rot0.re[pcmfmPkg::rotBits-1], rotOut[k].rot0.re} +
                  {rotOut[k].rot1.re[pcmfmPkg::rotBits-1], rotOut[k].rot1.re};
    end
  end

  // linear scan, strictly greater so lowest index keeps a tie
  always_comb begin
    scanIdx    = '0;
    scanMetric = metric[0];
    for (int k = 1; k < pcmfmPkg::numPts; k++) begin
      if (metric[k] > scanMetric) begin  // signed compare
        scanIdx    = pcmfmPkg::idxBits'(k);
        scanMetric = metric[k];
      end
    end
  end

  // result held until the next rotValid
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (rotValid) begin
      result.bestIdx    <= scanIdx;
      result.bestMetric <= scanMetric;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= rotValid;  // one cycle behind, single strobe
    end
  end

endmodule

// ==== rtl/apbRegs.sv ====
`timescale 1ns/1ps

module apbRegs (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [pcmfmPkg::apbAddrBits-1:0]    paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  output logic                                enable,       // gates symEn
  input  pcmfmPkg::phaseResult_t              result,
  input  logic                                resultValid
);

  pcmfmPkg::phaseResult_t resultReg;   // last captured result
  logic [15:0]            resultCount; // wraps
  logic                   access;      // access phase of any transfer
  logic                   hitCtrl;
  logic                   hitResult;
  logic                   hitCount;
  logic                   mapped;
  logic [31:0]            resultWord;  // readback layout

  assign pready = 1'b1;  // no wait states
  assign access = psel & penable;

  assign hitCtrl   = (paddr == pcmfmPkg::ctrlAddr);
  assign hitResult = (paddr == pcmfmPkg::resultAddr);
  assign hitCount  = (paddr == pcmfmPkg::countAddr);
  assign mapped    = hitCtrl | hitResult | hitCount;

  // unmapped offset, or write to a read-only register
  assign pslverr = access & (~mapped | (pwrite & (hitResult | hitCount)));

  // metric at 26:16, sign copied into 31:27, index at 4:0
  assign resultWord = {{5{resultReg.bestMetric[pcmfmPkg::metricBits-1]}},
                       resultReg.bestMetric,
                       11'b0,
                       resultReg.bestIdx};

  always_comb begin
    prdata = 32'b0;
    if (hitCtrl) begin
      prdata = {31'b0, enable};
    end else if (hitResult) begin
      prdata = resultWord;
    end else if (hitCount) begin
      prdata = {16'b0, resultCount};
    end
  end

  // ctrl is the only writable register
  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
    end else if (access && pwrite && hitCtrl) begin
      enable <= pwdata[0];
    end
  end

  // capture each strobe, readable the cycle after
  always_ff @(posedge clk) begin
    if (rst) begin
      resultReg   <= '0;
      resultCount <= 16'b0;
    end else if (resultValid) begin
      resultReg   <= result;
      resultCount <= resultCount + 16'd1;
    end
  end

endmodule

// ==== rtl/pcmfmPhaseTop.sv ====
`timescale 1ns/1ps

module pcmfmPhaseTop (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             symEn,        // one pulse per symbol
  input  pcmfmPkg::symPair_t               sampIn,
  output pcmfmPkg::phaseResult_t           result,
  output logic                             resultValid,  // 4 cycles after symEn
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [pcmfmPkg::apbAddrBits-1:0] paddr,
  input  logic [31:0]                      pwdata,
  output logic [31:0]                      prdata,
  output logic                             pready,
  output logic                             pslverr
);

  logic                                    enable;    // ctrl bit 0
  logic                                    rotValid;
  pcmfmPkg::rotPair_t [pcmfmPkg::numPts-1:0] rotOut;  // all rotated pairs

  rotator rotator_i (
    .clk      (clk),
    .rst      (rst),
    .symEn    (symEn),
    .enable   (enable),
    .sampIn   (sampIn),
    .rotOut   (rotOut),
    .rotValid (rotValid)
  );

  phaseSearch phaseSearch_i (
    .clk         (clk),
    .rst         (rst),
    .rotValid    (rotValid),
    .rotOut      (rotOut),
    .result      (result),
    .resultValid (resultValid)
  );

  apbRegs apbRegs_i (
    .clk         (clk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .enable      (enable),
    .result      (result),
    .resultValid (resultValid)
  );

endmodule

// ==== verif/pcmfmPhase_checker.sv ====
`timescale 1ns/1ps

module pcmfmPhaseChecker (
  input logic                   clk,
  input logic                   rst,
  input logic                   symEn,
  input logic                   enable,       // internal ctrl bit of the DUT
  input pcmfmPkg::symPair_t     sampIn,
  input pcmfmPkg::phaseResult_t result,
  input logic                   resultValid
);

  int errCount = 0;  // polled by the testbench

  logic [3:0]                             expValid;      // one bit per latency cycle
  logic [pcmfmPkg::idxBits-1:0]           expIdx [4];
  logic signed [pcmfmPkg::metricBits-1:0] expMetric [4];
  logic [pcmfmPkg::idxBits-1:0]           nowIdx;        // model answer for sampIn
  logic signed [pcmfmPkg::metricBits-1:0] nowMetric;
  logic                                   symEnQ;        // symEn one cycle back

  // real part of s rotated by p, scaled by 2^-(rotBits-1), wrapped to rotBits
  function automatic int rotReal(pcmfmPkg::cplx_t s, pcmfmPkg::cplx_t p);
    int full;
    int shifted;
    logic [pcmfmPkg::rotBits-1:0] low;
    full = int'($signed(s.re)) * int'($signed(p.re)) -
           int'($signed(s.im)) * int'($signed(p.im));
    shifted = full >>> (pcmfmPkg::rotBits - 1);
    low = shifted[pcmfmPkg::rotBits-1:0];
    return int'($signed(low));
  endfunction

  always_comb begin
    int m;
    int best;
    best = 0;
    nowIdx = '0;
    for (int k = 0; k < pcmfmPkg::numPts; k++) begin
      m = rotReal(sampIn.samp0, pcmfmPkg::phasorTable[k]) +
          rotReal(sampIn.samp1, pcmfmPkg::phasorTable[k]);
      if (k == 0 || m > best) begin  // lowest index keeps a tie
        best = m;
        nowIdx = pcmfmPkg::idxBits'(k);
      end
    end
    nowMetric = pcmfmPkg::metricBits'(best);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      expValid <= '0;
      symEnQ   <= 1'b0;
    end else begin
      expValid <= {expValid[2:0], symEn & enable};  // only accepted symbols
      symEnQ   <= symEn;
    end
  end

  // expected results ride along with expValid
  always_ff @(posedge clk) begin
    expIdx[0]    <= nowIdx;
    expMetric[0] <= nowMetric;
    for (int i = 1; i < 4; i++) begin
      expIdx[i]    <= expIdx[i-1];
      expMetric[i] <= expMetric[i-1];
    end
  end

  latencyA: assert property (@(posedge clk) disable iff (rst) resultValid == expValid[3])
    else begin
      errCount = errCount + 1;
      $error("error: resultValid 0x%h, expected 0x%h", $sampled(resultValid),
             $sampled(expValid[3]));
    end

  idxA: assert property (@(posedge clk) disable iff (rst)
                         resultValid |-> result.bestIdx == expIdx[3])
    else begin
      errCount = errCount + 1;
      $error("error: result.bestIdx 0x%h, expected 0x%h", $sampled(result.bestIdx),
             $sampled(expIdx[3]));
    end

  metricA: assert property (@(posedge clk) disable iff (rst)
                            resultValid |-> result.bestMetric == expMetric[3])
    else begin
      errCount = errCount + 1;
      $error("error: result.bestMetric 0x%h, expected 0x%h",
             $sampled(result.bestMetric), $sampled(expMetric[3]));
    end

  // multipliers are busy for two cycles
  spacingA: assert property (@(posedge clk) disable iff (rst) !(symEn && symEnQ))
    else begin
      errCount = errCount + 1;
      $error("symEn pulsed on two consecutive cycles");
    end

endmodule

// ==== verif/pcmfmPhaseTb.sv ====
`timescale 1ns/1ps

module pcmfmPhaseTb;

  logic                             clk;
  logic                             rst;
  logic                             symEn;
  pcmfmPkg::symPair_t               sampIn;
  pcmfmPkg::phaseResult_t           result;
  logic                             resultValid;
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [pcmfmPkg::apbAddrBits-1:0] paddr;
  logic [31:0]                      pwdata;
  logic [31:0]                      prdata;
  logic                             pready;
  logic                             pslverr;

  int   seed = 9;
  int   sentCount = 0;    // symbols sent while enabled
  int   strobeCount = 0;  // resultValid pulses seen
  logic enabledNow = 1'b0;
  int   ties [9] = '{0, 1, 2, -1, -2, 3, -3, 255, -255};  // equal real-valued samples

  pcmfmPhaseTop dut_i (
    .clk(clk), .rst(rst), .symEn(symEn), .sampIn(sampIn),
    .result(result), .resultValid(resultValid),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  bind pcmfmPhaseTop pcmfmPhaseChecker checker_i (
    .clk(clk), .rst(rst), .symEn(symEn), .enable(enable), .sampIn(sampIn),
    .result(result), .resultValid(resultValid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  always @(posedge clk) begin
    if (resultValid === 1'b1) strobeCount++;  // old value, before this edge's update
  end

  always @(negedge clk) begin
    if (dut_i.checker_i.errCount != 0) failRun("a checker assertion failed");
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // called just after penable rises, checks land mid low phase
  task automatic waitReady();
    int waited;
    waited = 0;
    #1;
    while (pready !== 1'b1) begin
      @(negedge clk);
      #1;
      waited++;
      if (waited > 20) failRun("timeout: pready never rose in the access phase");
    end
  endtask

  task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data,
                          input logic expErr);
    @(negedge clk);
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;  // access phase
    waitReady();
    if (pslverr !== expErr)
      failRun($sformatf("error: pslverr on write to 0x%h is 0x%h, expected 0x%h",
                        addr, pslverr, expErr));
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apbRead(input logic [3:0] addr, input logic [31:0] expData,
                         input logic expErr);
    @(negedge clk);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    waitReady();
    if (pslverr !== expErr)
      failRun($sformatf("error: pslverr on read of 0x%h is 0x%h, expected 0x%h",
                        addr, pslverr, expErr));
    if (!expErr && prdata !== expData)
      failRun($sformatf("error: prdata at 0x%h is 0x%h, expected 0x%h",
                        addr, prdata, expData));
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // one symEn pulse, next pulse may follow gap cycles later
  task automatic sendSymbol(input pcmfmPkg::symPair_t s, input int gap);
    @(negedge clk);
    symEn = 1'b1;
    sampIn = s;
    if (enabledNow) sentCount++;
    @(negedge clk);
    symEn = 1'b0;
    repeat (gap - 2) @(negedge clk);
  endtask

  task automatic waitResults();
    int waited;
    waited = 0;
    while (strobeCount != sentCount) begin
      @(negedge clk);
      waited++;
      if (waited > 50) failRun("timeout: fewer results than accepted symbols");
    end
  endtask

  function automatic pcmfmPkg::symPair_t randomPair();
    pcmfmPkg::symPair_t s;
    s.samp0.re = pcmfmPkg::rotBits'($random(seed) % 256);  // within +-255
    s.samp0.im = pcmfmPkg::rotBits'($random(seed) % 256);
    s.samp1.re = pcmfmPkg::rotBits'($random(seed) % 256);
    s.samp1.im = pcmfmPkg::rotBits'($random(seed) % 256);
    return s;
  endfunction

  function automatic pcmfmPkg::symPair_t realPair(input int v);
    pcmfmPkg::symPair_t s;
    s.samp0.re = pcmfmPkg::rotBits'(v);
    s.samp0.im = '0;
    s.samp1 = s.samp0;  // both samples equal
    return s;
  endfunction

  initial begin
    int gap;
    rst = 1'b1;
    symEn = 1'b0;
    sampIn = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // registers cleared by reset
    apbRead(pcmfmPkg::ctrlAddr, 32'h0, 1'b0);
    apbRead(pcmfmPkg::resultAddr, 32'h0, 1'b0);
    apbRead(pcmfmPkg::countAddr, 32'h0, 1'b0);

    // disabled, symbols dropped
    for (int i = 0; i < 6; i++) sendSymbol(randomPair(), 3);
    repeat (8) @(negedge clk);
    if (strobeCount != 0)
      failRun($sformatf("error: strobeCount 0x%h, expected 0x0", strobeCount));

    apbWrite(pcmfmPkg::ctrlAddr, 32'h1, 1'b0);
    apbRead(pcmfmPkg::ctrlAddr, 32'h1, 1'b0);
    enabledNow = 1'b1;

    for (int i = 0; i < 200; i++) begin
      gap = 2 + ($unsigned($random(seed)) % 4);  // 2..5 cycles apart
      sendSymbol(randomPair(), gap);
    end
    waitResults();

    foreach (ties[i]) sendSymbol(realPair(ties[i]), 2);
    waitResults();

    // 200 on phasor 0 gives 199 per sample, -200 picks phasor 10
    sendSymbol(realPair(200), 2);
    waitResults();
    apbRead(pcmfmPkg::resultAddr, 32'h018E_0000, 1'b0);
    sendSymbol(realPair(-200), 2);
    waitResults();
    apbRead(pcmfmPkg::resultAddr, 32'h018E_000A, 1'b0);
    apbRead(pcmfmPkg::countAddr, 32'(sentCount), 1'b0);

    // read-only and unmapped offsets
    apbWrite(pcmfmPkg::resultAddr, 32'hFFFF_FFFF, 1'b1);
    apbRead(pcmfmPkg::resultAddr, 32'h018E_000A, 1'b0);
    apbWrite(pcmfmPkg::countAddr, 32'h0, 1'b1);
    apbRead(pcmfmPkg::countAddr, 32'(sentCount), 1'b0);
    apbWrite(4'h1, 32'h0, 1'b1);
    apbWrite(4'hC, 32'h0, 1'b1);
    apbRead(4'hC, 32'h0, 1'b1);
    apbRead(4'h2, 32'h0, 1'b1);
    apbRead(pcmfmPkg::ctrlAddr, 32'h1, 1'b0);

    repeat (4) @(negedge clk);
    if (dut_i.checker_i.errCount != 0) begin
      failRun("checker reported errors");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== pcmfmPhase.f ====
rtl/pcmfmPkg.sv
rtl/rotMult.sv
rtl/rotator.sv
rtl/phaseSearch.sv
rtl/apbRegs.sv
rtl/pcmfmPhaseTop.sv
verif/pcmfmPhase_checker.sv
verif/pcmfmPhaseTb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := pcmfmPhaseTb
FILELIST := pcmfmPhase.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
